// ==== hw/spu_lane.sv ====
`timescale 1ns/10ps
`default_nettype none

module spu_lane (
    input  var logic              clk,
    input  var logic              arst_n,

    input  var logic              cmd_req,
    input  var spu_pkg::spu_cmd_t cmd,
    output var logic              cmd_ack,
    output var spu_pkg::spu_rsp_t rsp,

    output var spu_pkg::rf_req_t  rf_req,
    input  var logic              rf_gnt,
    input  var spu_pkg::rf_rsp_t  rf_rsp
);

    typedef enum logic [2:0] {
        IDLE,
        RD_A,
        RD_B,
        EXEC,
        WAIT,
        WR,
        ACK,
        DONE
    } state_e;

    state_e            state;
    logic              rd_pend;        // read granted, data not back yet
    spu_pkg::spu_cmd_t cmd_q;
    spu_pkg::data_t    opa;
    spu_pkg::data_t    opb;
    spu_pkg::data_t    result_q;

    logic              use_arith;
    logic              logic_valid;
    spu_pkg::data_t    logic_data;
    logic              arith_valid;
    spu_pkg::data_t    arith_data;

    function automatic logic needs_a(spu_pkg::spu_cmd_t c);
        return !(c.op inside {spu_pkg::OP_MOV, spu_pkg::OP_CLR});
    endfunction

    function automatic logic needs_b(spu_pkg::spu_cmd_t c);
        return !c.use_imm && (c.op != spu_pkg::OP_CLR);
    endfunction

    assign use_arith = cmd_q.op inside {spu_pkg::OP_ADD, spu_pkg::OP_SUB};

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state   <= IDLE;
            rd_pend <= 1'b0;
            cmd_ack <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (cmd_req) begin
                        if (needs_a(cmd)) begin
                            state <= RD_A;
                        end else if (needs_b(cmd)) begin
                            state <= RD_B;
                        end else begin
                            state <= EXEC;
                        end
                    end
                end
                RD_A, RD_B: begin
                    if (!rd_pend && rf_gnt) begin
                        rd_pend <= 1'b1;
                    end else if (rd_pend && rf_rsp.rvalid) begin
                        rd_pend <= 1'b0;
                        state   <= (state == RD_A && needs_b(cmd_q)) ? RD_B : EXEC;
                    end
                end
                EXEC: state <= WAIT;           // single issue pulse
                WAIT: begin
                    if (logic_valid || arith_valid) begin
                        state <= WR;
                    end
                end
                WR: begin
                    if (rf_gnt) begin
                        cmd_ack <= 1'b1;
                        state   <= ACK;
                    end
                end
                ACK: begin
                    if (!cmd_req) begin
                        cmd_ack <= 1'b0;
                        state   <= DONE;
                    end
                end
                default: state <= IDLE;        // DONE, host sees ack low
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE && cmd_req) begin
            cmd_q <= cmd;
            opb   <= cmd.imm;                  // overwritten by RD_B if needed
        end
        if (rd_pend && rf_rsp.rvalid) begin
            if (state == RD_A) begin
                opa <= rf_rsp.rdata;
            end else begin
                opb <= rf_rsp.rdata;
            end
        end
        if (state == WAIT) begin
            result_q <= logic_valid ? logic_data : arith_data;
        end
    end

    always_comb begin
        rf_req = '0;
        case (state)
            RD_A: begin
                rf_req.valid = !rd_pend;
                rf_req.addr  = cmd_q.src_a;
            end
            RD_B: begin
                rf_req.valid = !rd_pend;
                rf_req.addr  = cmd_q.src_b;
            end
            WR: begin
                rf_req.valid = 1'b1;
                rf_req.write = 1'b1;
                rf_req.addr  = cmd_q.dst;
                rf_req.wdata = result_q;
            end
            default: ;
        endcase
    end

    // stable while ack is high
    assign rsp.result = result_q;
    assign rsp.dst    = cmd_q.dst;

    // CLR goes through the bitwise unit as a clear
    spu_op_logic u_logic (
        .clk     (clk),
        .arst_n  (arst_n),
        .cke     (1'b1),
        .s_data0 (opa),
        .s_data1 (opb),
        .s_op    (cmd_q.op),
        .s_clear ((state == EXEC) && (cmd_q.op == spu_pkg::OP_CLR)),
        .s_valid ((state == EXEC) && !use_arith),
        .m_data  (logic_data),
        .m_valid (logic_valid)
    );

    spu_op_arith u_arith (
        .clk     (clk),
        .arst_n  (arst_n),
        .cke     (1'b1),
        .s_data0 (opa),
        .s_data1 (opb),
        .s_op    (cmd_q.op),
        .s_clear (1'b0),
        .s_valid ((state == EXEC) && use_arith),
        .m_data  (arith_data),
        .m_valid (arith_valid)
    );

endmodule

`default_nettype wire

// ==== hw/spu_op_arith.sv ====
`timescale 1ns/10ps
`default_nettype none

module spu_op_arith (
    input  var logic             clk,
    input  var logic             arst_n,
    input  var logic             cke,

    input  var spu_pkg::data_t   s_data0,
    input  var spu_pkg::data_t   s_data1,
    input  var spu_pkg::spu_op_e s_op,
    input  var logic             s_clear,
    input  var logic             s_valid,

    output var spu_pkg::data_t   m_data,
    output var logic             m_valid
);

    spu_pkg::data_t st0_data;

    // carry out is dropped, wraps modulo 2^16
    assign st0_data = (s_op == spu_pkg::OP_SUB) ? s_data0 - s_data1
                                                : s_data0 + s_data1;

    spu_op_delay #(
        .LATENCY (spu_pkg::ARITH_LATENCY)
    ) u_latency (
        .clk     (clk),
        .arst_n  (arst_n),
        .cke     (cke),
        .s_data  (st0_data),
        .s_clear (s_clear),
        .s_valid (s_valid),
        .m_data  (m_data),
        .m_valid (m_valid)
    );

endmodule

`default_nettype wire

// ==== hw/spu_op_delay.sv ====
`timescale 1ns/10ps
`default_nettype none

module spu_op_delay #(
    parameter int LATENCY = 1
) (
    input  var logic           clk,
    input  var logic           arst_n,
    input  var logic           cke,

    input  var spu_pkg::data_t s_data,
    input  var logic           s_clear,
    input  var logic           s_valid,

    output var spu_pkg::data_t m_data,
    output var logic           m_valid
);

    if (LATENCY == 0) begin : g_wire
        assign m_data  = s_clear ? '0 : s_data;   // clear still applies
        assign m_valid = s_valid;
    end else begin : g_pipe
        spu_pkg::data_t     stg_data [LATENCY];
        logic [LATENCY-1:0] stg_clear;
        logic [LATENCY-1:0] stg_valid;

        spu_pkg::data_t     in_data  [LATENCY];   // input side of each stage
        logic [LATENCY-1:0] in_clear;
        logic [LATENCY-1:0] in_valid;

        always_comb begin
            in_data[0]  = s_data;
            in_clear[0] = s_clear;
            in_valid[0] = s_valid;
            for (int i = 1; i < LATENCY; i++) begin
                in_data[i]  = stg_data[i-1];
                in_clear[i] = stg_clear[i-1];
                in_valid[i] = stg_valid[i-1];
            end
        end

        // flags walk along beside the data
        always_ff @(posedge clk or negedge arst_n) begin
            if (!arst_n) begin
                stg_clear <= '0;
                stg_valid <= '0;
            end else if (cke) begin
                stg_clear <= in_clear;
                stg_valid <= in_valid;
            end
        end

        always_ff @(posedge clk) begin
            if (cke) begin
                for (int i = 0; i < LATENCY; i++) begin
                    if (in_clear[i]) begin
                        stg_data[i] <= '0;
                    end else if (in_valid[i]) begin
                        stg_data[i] <= in_data[i];
                    end                          // otherwise hold
                end
            end
        end

        assign m_data  = stg_data[LATENCY-1];
        assign m_valid = stg_valid[LATENCY-1];
    end

endmodule

`default_nettype wire

// ==== hw/spu_op_logic.sv ====
`timescale 1ns/10ps
`default_nettype none

module spu_op_logic (
    input  var logic             clk,
    input  var logic             arst_n,
    input  var logic             cke,

    input  var spu_pkg::data_t   s_data0,
    input  var spu_pkg::data_t   s_data1,
    input  var spu_pkg::spu_op_e s_op,
    input  var logic             s_clear,
    input  var logic             s_valid,

    output var spu_pkg::data_t   m_data,
    output var logic             m_valid
);

    spu_pkg::data_t st0_data;

    always_comb begin
        case (s_op)
            spu_pkg::OP_AND: st0_data = s_data0 & s_data1;
            spu_pkg::OP_OR:  st0_data = s_data0 | s_data1;
            spu_pkg::OP_XOR: st0_data = s_data0 ^ s_data1;
            spu_pkg::OP_MOV: st0_data = s_data1;      // operand b straight through
            default:         st0_data = '0;           // CLR arrives with s_clear
        endcase
    end

    spu_op_delay #(
        .LATENCY (spu_pkg::LOGIC_LATENCY)
    ) u_latency (
        .clk     (clk),
        .arst_n  (arst_n),
        .cke     (cke),
        .s_data  (st0_data),
        .s_clear (s_clear),
        .s_valid (s_valid),
        .m_data  (m_data),
        .m_valid (m_valid)
    );

endmodule

`default_nettype wire

// ==== hw/spu_pkg.sv ====
package spu_pkg;

    // data path and register file geometry
    localparam int DATA_BITS     = 16;
    localparam int REG_ADDR_BITS = 4;
    localparam int NUM_REGS      = 2 ** REG_ADDR_BITS;
    localparam int NUM_LANES     = 2;
    localparam int LANE_BITS     = 1;      // index width for NUM_LANES

    // operation unit latencies in cycles
    localparam int LOGIC_LATENCY = 2;
    localparam int ARITH_LATENCY = 3;

    typedef logic [DATA_BITS-1:0]     data_t;
    typedef logic [REG_ADDR_BITS-1:0] reg_addr_t;
    typedef logic [LANE_BITS-1:0]     lane_idx_t;

    typedef enum logic [2:0] {
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_ADD,                            // modulo 2^16
        OP_SUB,                            // modulo 2^16
        OP_MOV,                            // passes operand b
        OP_CLR                             // result is zero
    } spu_op_e;

    // host command
    typedef struct packed {
        spu_op_e   op;
        reg_addr_t dst;
        reg_addr_t src_a;
        reg_addr_t src_b;
        logic      use_imm;                // imm replaces src_b
        data_t     imm;
    } spu_cmd_t;

    // host response, valid while ack is high
    typedef struct packed {
        data_t     result;
        reg_addr_t dst;
    } spu_rsp_t;

    // lane to register file
    typedef struct packed {
        logic      valid;
        logic      write;
        reg_addr_t addr;
        data_t     wdata;
    } rf_req_t;

    typedef struct packed {
        logic      rvalid;                 // one cycle after the read grant
        data_t     rdata;
    } rf_rsp_t;

endpackage

// ==== hw/spu_regfile_arb.sv ====
`timescale 1ns/10ps
`default_nettype none

module spu_regfile_arb (
    input  var logic             clk,
    input  var logic             arst_n,

    input  var spu_pkg::rf_req_t rf_req [spu_pkg::NUM_LANES],
    output var logic             rf_gnt [spu_pkg::NUM_LANES],
    output var spu_pkg::rf_rsp_t rf_rsp [spu_pkg::NUM_LANES]
);

    spu_pkg::data_t    regs [spu_pkg::NUM_REGS];

    spu_pkg::lane_idx_t last_q;        // lane granted most recently
    spu_pkg::lane_idx_t win;
    logic               any_gnt;
    spu_pkg::rf_req_t   gnt_req;

    logic               rd_valid_q;
    spu_pkg::lane_idx_t rd_lane_q;
    spu_pkg::data_t     rd_data_q;

    // round robin, search starts one past the last winner
    always_comb begin
        int idx;
        win     = last_q;
        any_gnt = 1'b0;
        for (int i = 1; i <= spu_pkg::NUM_LANES; i++) begin
            idx = (int'(last_q) + i) % spu_pkg::NUM_LANES;
            if (!any_gnt && rf_req[idx].valid) begin
                any_gnt = 1'b1;
                win     = spu_pkg::lane_idx_t'(idx);
            end
        end
    end

    assign gnt_req = rf_req[win];

    always_comb begin
        for (int i = 0; i < spu_pkg::NUM_LANES; i++) begin
            rf_gnt[i]        = any_gnt && (win == spu_pkg::lane_idx_t'(i));
            rf_rsp[i].rvalid = rd_valid_q && (rd_lane_q == spu_pkg::lane_idx_t'(i));
            rf_rsp[i].rdata  = rd_data_q;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            last_q     <= '1;          // lane 0 first after reset
            rd_valid_q <= 1'b0;
            rd_lane_q  <= '0;
            for (int r = 0; r < spu_pkg::NUM_REGS; r++) begin
                regs[r] <= '0;
            end
        end else begin
            rd_valid_q <= any_gnt && !gnt_req.write;
            if (any_gnt) begin
                last_q    <= win;
                rd_lane_q <= win;
                if (gnt_req.write) begin
                    regs[gnt_req.addr] <= gnt_req.wdata;
                end
            end
        end
    end

    // read data, qualified by rd_valid_q
    always_ff @(posedge clk) begin
        if (any_gnt && !gnt_req.write) begin
            rd_data_q <= regs[gnt_req.addr];
        end
    end

endmodule

`default_nettype wire

// ==== hw/spu_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module spu_top (
    input  var logic              clk,
    input  var logic              arst_n,

    input  var logic              cmd_req [spu_pkg::NUM_LANES],
    input  var spu_pkg::spu_cmd_t cmd     [spu_pkg::NUM_LANES],
    output var logic              cmd_ack [spu_pkg::NUM_LANES],
    output var spu_pkg::spu_rsp_t rsp     [spu_pkg::NUM_LANES]
);

    spu_pkg::rf_req_t rf_req [spu_pkg::NUM_LANES];
    logic             rf_gnt [spu_pkg::NUM_LANES];
    spu_pkg::rf_rsp_t rf_rsp [spu_pkg::NUM_LANES];

    // identical lanes, each with its own host port
    for (genvar i = 0; i < spu_pkg::NUM_LANES; i++) begin : g_lane
        spu_lane u_lane (
            .clk     (clk),
            .arst_n  (arst_n),
            .cmd_req (cmd_req[i]),
            .cmd     (cmd[i]),
            .cmd_ack (cmd_ack[i]),
            .rsp     (rsp[i]),
            .rf_req  (rf_req[i]),
            .rf_gnt  (rf_gnt[i]),
            .rf_rsp  (rf_rsp[i])
        );
    end

    // shared register file
    spu_regfile_arb u_regfile (
        .clk    (clk),
        .arst_n (arst_n),
        .rf_req (rf_req),
        .rf_gnt (rf_gnt),
        .rf_rsp (rf_rsp)
    );

endmodule

`default_nettype wire

// ==== run.sh ====
#!/usr/bin/env bash
# Build the SPU testbench with Verilator and run it.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module spu_tb \
    -f spu_top.f \
    -o spu_sim

status=0
output=$(./obj_dir/spu_sim 2>&1) || status=$?
echo "$output"

if grep -q "^Result: PASSED$" <<< "$output"; then
    exit 0
fi
echo "simulation did not pass (exit status ${status})"
exit 1

// ==== spu_top.f ====
hw/spu_pkg.sv
hw/spu_op_delay.sv
hw/spu_op_logic.sv
hw/spu_op_arith.sv
hw/spu_regfile_arb.sv
hw/spu_lane.sv
hw/spu_top.sv
test/spu_tb.sv

// ==== test/spu_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module spu_tb;

    localparam int CLK_PERIOD = 100;
    localparam int MAX_CMDS   = 80;            // watchdog budget

    logic              clk;
    logic              arst_n;
    logic              cmd_req [spu_pkg::NUM_LANES];
    spu_pkg::spu_cmd_t cmd     [spu_pkg::NUM_LANES];
    logic              cmd_ack [spu_pkg::NUM_LANES];
    spu_pkg::spu_rsp_t rsp     [spu_pkg::NUM_LANES];

    spu_pkg::data_t    shadow  [spu_pkg::NUM_REGS];    // model of the register file
    spu_pkg::spu_rsp_t exp_rsp [spu_pkg::NUM_LANES];
    logic [15:0]       lfsr;
    string             test_name;

    spu_top dut (
        .clk     (clk),
        .arst_n  (arst_n),
        .cmd_req (cmd_req),
        .cmd     (cmd),
        .cmd_ack (cmd_ack),
        .rsp     (rsp)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("Result: FAILED");
        $fatal(1);
    endtask

    // galois lfsr, one step per bit
    function automatic logic [15:0] rand_bits(input int n);
        logic [15:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            v    = {v[14:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
        end
        return v;
    endfunction

    function automatic spu_pkg::spu_op_e logic_op(input logic [1:0] v);
        case (v)
            2'd0:    return spu_pkg::OP_AND;
            2'd1:    return spu_pkg::OP_OR;
            default: return spu_pkg::OP_XOR;
        endcase
    endfunction

    function automatic spu_pkg::spu_op_e any_op(input logic [2:0] v);
        case (v)
            3'd0:    return spu_pkg::OP_AND;
            3'd1:    return spu_pkg::OP_OR;
            3'd2:    return spu_pkg::OP_XOR;
            3'd3:    return spu_pkg::OP_ADD;
            3'd4:    return spu_pkg::OP_SUB;
            3'd6:    return spu_pkg::OP_CLR;
            default: return spu_pkg::OP_MOV;
        endcase
    endfunction

    function automatic spu_pkg::data_t model_result(
        input spu_pkg::spu_op_e op,
        input spu_pkg::data_t   a,
        input spu_pkg::data_t   b
    );
        case (op)
            spu_pkg::OP_AND: return a & b;
            spu_pkg::OP_OR:  return a | b;
            spu_pkg::OP_XOR: return a ^ b;
            spu_pkg::OP_ADD: return a + b;     // carry lost in 16 bits
            spu_pkg::OP_SUB: return a - b;
            spu_pkg::OP_MOV: return b;
            default:         return '0;
        endcase
    endfunction

    function automatic spu_pkg::spu_cmd_t make_cmd(
        input spu_pkg::spu_op_e   op,
        input spu_pkg::reg_addr_t dst,
        input spu_pkg::reg_addr_t src_a,
        input spu_pkg::reg_addr_t src_b,
        input logic               use_imm,
        input spu_pkg::data_t     imm
    );
        spu_pkg::spu_cmd_t c;
        c.op      = op;
        c.dst     = dst;
        c.src_a   = src_a;
        c.src_b   = src_b;
        c.use_imm = use_imm;
        c.imm     = imm;
        return c;
    endfunction

    // half >= 0 keeps all registers in that lane's half
    function automatic spu_pkg::spu_cmd_t random_cmd(
        input spu_pkg::spu_op_e op,
        input logic             use_imm,
        input int               half
    );
        logic [15:0] d;
        logic [15:0] a;
        logic [15:0] b;
        d = rand_bits(4);
        a = rand_bits(4);
        b = rand_bits(4);
        if (half >= 0) begin
            d[3] = half[0];
            a[3] = half[0];
            b[3] = half[0];
        end
        return make_cmd(op, d[3:0], a[3:0], b[3:0], use_imm, rand_bits(16));
    endfunction

    // one four-phase transfer on one lane
    task automatic run_cmd(input int lane, input spu_pkg::spu_cmd_t c);
        spu_pkg::data_t a;
        spu_pkg::data_t b;
        spu_pkg::data_t r;
        a = shadow[c.src_a];
        b = c.use_imm ? c.imm : shadow[c.src_b];
        r = model_result(c.op, a, b);
        @(negedge clk);
        exp_rsp[lane].result = r;
        exp_rsp[lane].dst    = c.dst;
        cmd[lane]            = c;
        cmd_req[lane]        = 1'b1;
        while (!cmd_ack[lane]) @(negedge clk);
        shadow[c.dst] = r;
        cmd_req[lane] = 1'b0;
        while (cmd_ack[lane]) @(negedge clk);
    endtask

    for (genvar i = 0; i < spu_pkg::NUM_LANES; i++) begin : g_check
        rsp_match: assert property (@(posedge clk) disable iff (!arst_n)
            cmd_ack[i] |-> (rsp[i] == exp_rsp[i]))
            else fail_run($sformatf(
                "[ERROR] %s lane %0d: expected result %h dst %0d, actual result %h dst %0d",
                test_name, i, exp_rsp[i].result, exp_rsp[i].dst, rsp[i].result, rsp[i].dst));
        ack_needs_req: assert property (@(posedge clk) disable iff (!arst_n)
            $rose(cmd_ack[i]) |-> $past(cmd_req[i]))
            else fail_run($sformatf("lane %0d raised ack without a request", i));
        ack_held: assert property (@(posedge clk) disable iff (!arst_n)
            $fell(cmd_ack[i]) |-> !$past(cmd_req[i]))
            else fail_run($sformatf("lane %0d dropped ack while req was still high", i));
        ack_low_at_req: assert property (@(posedge clk) disable iff (!arst_n)
            $rose(cmd_req[i]) |-> !cmd_ack[i])
            else fail_run($sformatf("lane %0d ack still high at a new request", i));
    end

    initial begin
        #(MAX_CMDS * 40 * CLK_PERIOD);
        fail_run("simulation timed out waiting for the DUT");
    end

    initial begin
        spu_pkg::spu_cmd_t c0;
        spu_pkg::spu_cmd_t c1;
        logic [15:0]       v;
        clk       = 1'b0;
        arst_n    = 1'b0;
        lfsr      = 16'd28024;
        test_name = "reset";
        for (int i = 0; i < spu_pkg::NUM_LANES; i++) begin
            cmd_req[i] = 1'b0;
            cmd[i]     = '0;
            exp_rsp[i] = '0;
        end
        for (int r = 0; r < spu_pkg::NUM_REGS; r++) begin
            shadow[r] = '0;
        end
        repeat (5) @(negedge clk);
        arst_n = 1'b1;
        assert (!cmd_ack[0] && !cmd_ack[1])
            else fail_run($sformatf("[ERROR] %s: expected acks 00, actual %b%b",
                                    test_name, cmd_ack[1], cmd_ack[0]));
        for (int r = 0; r < spu_pkg::NUM_REGS; r++) begin
            v = 16'(r);
            run_cmd(r % 2, make_cmd(spu_pkg::OP_MOV, v[3:0], '0, v[3:0], 1'b0, '0));
        end

        test_name = "logic_ops";
        for (int k = 0; k < 6; k++) begin
            run_cmd(k % 2, random_cmd(spu_pkg::OP_MOV, 1'b1, -1));   // seed registers
        end
        for (int k = 0; k < 10; k++) begin
            v  = rand_bits(2);
            c0 = random_cmd(logic_op(v[1:0]), 1'b0, -1);
            run_cmd(k % 2, c0);
            v = rand_bits(4);
            run_cmd((k + 1) % 2, make_cmd(spu_pkg::OP_MOV, v[3:0], '0, c0.dst, 1'b0, '0));
        end

        test_name = "arith_wrap";
        run_cmd(0, make_cmd(spu_pkg::OP_CLR, 4'd1, '0, '0, 1'b0, '0));
        run_cmd(1, make_cmd(spu_pkg::OP_MOV, 4'd2, '0, '0, 1'b1, 16'h0001));
        run_cmd(0, make_cmd(spu_pkg::OP_SUB, 4'd3, 4'd1, 4'd2, 1'b0, '0));       // 0 - 1
        run_cmd(1, make_cmd(spu_pkg::OP_ADD, 4'd4, 4'd3, '0, 1'b1, 16'h0001));   // ffff + 1
        for (int k = 0; k < 6; k++) begin
            v = rand_bits(2);
            run_cmd(k % 2, random_cmd(v[0] ? spu_pkg::OP_SUB : spu_pkg::OP_ADD, v[1], -1));
        end

        test_name = "imm_and_clr";
        for (int k = 0; k < 4; k++) begin
            v = rand_bits(2);
            run_cmd(k % 2, random_cmd(logic_op(v[1:0]), 1'b1, -1));
        end
        for (int k = 0; k < 2; k++) begin
            run_cmd(k, random_cmd(spu_pkg::OP_CLR, 1'b0, -1));
        end

        test_name = "dual_lane";
        for (int k = 0; k < 10; k++) begin
            v  = rand_bits(4);
            c0 = random_cmd(any_op(v[2:0]), v[3], 0);
            v  = rand_bits(4);
            c1 = random_cmd(any_op(v[2:0]), v[3], 1);
            fork
                run_cmd(0, c0);
                run_cmd(1, c1);
            join
        end

        repeat (2) @(negedge clk);
        $display("Result: PASSED");
        $finish;
    end

endmodule

`default_nettype wire
